/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = bn_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run $(TOP) with $(SIM)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+include
hdl/bn_data_pkg.sv
hdl/bn_ctrl_pkg.sv
hdl/bn_input_ctrl.sv
hdl/batch_stats.sv
hdl/sample_buffer.sv
hdl/bn_transform.sv
hdl/bn_top.sv
verification/bn_clk_gen.sv
verification/bn_tb.sv

/* hdl/batch_stats.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bn_config.svh"

module batch_stats
  import bn_data_pkg::*;
  import bn_ctrl_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire bn_sample_t train_i,
  input  wire logic       train_valid_i,
  output bn_stats_t       stats_o,
  output logic            stats_valid_o
);

  stats_state_e                 state_q;
  logic [`BN_IDX_W-1:0]         cnt_q;
  logic signed [`BN_SUM_W-1:0]  sum_q;
  bn_data_t                     max_q;
  bn_data_t                     min_q;

  logic                         restart;
  logic signed [`BN_SUM_W-1:0]  sum_nx;
  bn_data_t                     max_nx;
  bn_data_t                     min_nx;
  logic [`BN_DATA_W-1:0]        range;
  logic [4:0]                   lead;
  logic [4:0]                   k_nx;
  bn_data_t                     mean_nx;

  ////////////////////
  // Running sum, max and min including the current sample
  always_comb begin
    restart = (state_q == ST_IDLE) || (train_i.idx == '0);
    if (restart) begin
      sum_nx = `BN_SUM_W'(train_i.data);
      max_nx = train_i.data;
      min_nx = train_i.data;
    end else begin
      sum_nx = sum_q + `BN_SUM_W'(train_i.data);
      max_nx = (train_i.data > max_q) ? train_i.data : max_q;
      min_nx = (train_i.data < min_q) ? train_i.data : min_q;
    end

    // Range always fits unsigned in the sample width
    range = max_nx - min_nx;
    lead  = '0;
    for (int i = 0; i < `BN_DATA_W; i++) begin
      if (range[i]) begin
        lead = 5'(i);
      end
    end
    // Zero range leaves lead at 0 so k clamps to 0 too
    if (lead >= 5'(`BN_APPROX_SHIFT)) begin
      k_nx = lead - 5'(`BN_APPROX_SHIFT);
    end else begin
      k_nx = '0;
    end

    // Floor of sum / 8
    mean_nx = sum_nx[`BN_SUM_W-1:`BN_IDX_W];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= ST_IDLE;
      cnt_q         <= '0;
      stats_valid_o <= 1'b0;
    end else begin
      stats_valid_o <= train_valid_i && train_i.last;
      if (train_valid_i) begin
        cnt_q   <= cnt_q + 1'b1;
        state_q <= train_i.last ? ST_IDLE : ST_GATHER;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (train_valid_i) begin
      sum_q <= sum_nx;
      max_q <= max_nx;
      min_q <= min_nx;
    end
    if (train_valid_i && train_i.last) begin
      stats_o.mean <= mean_nx;
      stats_o.k    <= k_nx;
    end
  end

  // Index from input control tracks the local sample count
  a_idx_follows_cnt: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    train_valid_i |-> (train_i.idx == cnt_q)
  );

endmodule

`default_nettype wire

/* hdl/bn_ctrl_pkg.sv */
`default_nettype none

package bn_ctrl_pkg;

  typedef enum logic {
    MODE_BYPASS = 1'b0,
    MODE_TRAIN  = 1'b1
  } bn_mode_e;

  typedef enum logic {
    ST_IDLE   = 1'b0,
    ST_GATHER = 1'b1
  } stats_state_e;

  typedef enum logic {
    RP_IDLE = 1'b0,
    RP_RUN  = 1'b1
  } replay_state_e;

endpackage

`default_nettype wire

/* hdl/bn_data_pkg.sv */
`default_nettype none

`include "bn_config.svh"

package bn_data_pkg;

  typedef logic signed [`BN_DATA_W-1:0] bn_data_t;

  // Scale and shift for the normalized output
  typedef struct packed {
    logic signed [`BN_DATA_W-1:0] gamma;
    logic signed [`BN_DATA_W-1:0] beta;
  } bn_param_t;

  // Training sample with its position in the batch
  typedef struct packed {
    bn_data_t             data;
    logic [`BN_IDX_W-1:0] idx;
    logic                 last;
  } bn_sample_t;

  // Batch mean and power-of-two deviation
  typedef struct packed {
    logic signed [`BN_DATA_W-1:0] mean;
    logic [4:0]                   k;
  } bn_stats_t;

  typedef struct packed {
    bn_data_t data;
    logic     first;
  } bn_replay_t;

endpackage

`default_nettype wire

/* hdl/bn_input_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bn_config.svh"

module bn_input_ctrl
  import bn_data_pkg::*;
  import bn_ctrl_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire bn_data_t   x_i,
  input  wire logic       x_valid_i,
  input  wire bn_mode_e   mode_i,
  input  wire bn_param_t  param_i,
  input  wire logic       param_valid_i,
  output bn_sample_t      train_o,
  output logic            train_valid_o,
  output bn_data_t        bypass_o,
  output logic            bypass_valid_o,
  output bn_param_t       param_o
);

  bn_mode_e             mode_q;
  logic [`BN_IDX_W-1:0] idx_q;
  logic                 is_train;

  assign is_train = (mode_i == MODE_TRAIN);

  ////////////////////
  // Control and parameter registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mode_q         <= MODE_BYPASS;
      idx_q          <= '0;
      train_valid_o  <= 1'b0;
      bypass_valid_o <= 1'b0;
      param_o.gamma  <= `BN_DATA_W'(1 << `BN_GAMMA_FRAC);
      param_o.beta   <= '0;
    end else begin
      mode_q         <= mode_i;
      train_valid_o  <= x_valid_i && is_train;
      bypass_valid_o <= x_valid_i && !is_train;
      // Index wraps after the eighth sample
      if (x_valid_i && is_train) begin
        idx_q <= idx_q + 1'b1;
      end
      if (param_valid_i) begin
        param_o <= param_i;
      end
    end
  end

  ////////////////////
  // Sample payload, both paths see the same word
  always_ff @(posedge clk_i) begin
    train_o.data <= x_i;
    train_o.idx  <= idx_q;
    train_o.last <= (idx_q == `BN_IDX_W'(`BN_MINI_BATCH - 1));
    bypass_o     <= x_i;
  end

  // Mode may only change on a batch boundary
  a_mode_on_boundary: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mode_i != mode_q) |-> (idx_q == '0)
  );

endmodule

`default_nettype wire

/* hdl/bn_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bn_top
  import bn_data_pkg::*;
  import bn_ctrl_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire bn_data_t  x_i,
  input  wire logic      x_valid_i,
  input  wire bn_mode_e  mode_i,
  input  wire bn_param_t param_i,
  input  wire logic      param_valid_i,
  output bn_data_t       y_o,
  output logic           y_valid_o
);

  bn_sample_t train;
  logic       train_valid;
  bn_data_t   bypass;
  logic       bypass_valid;
  bn_param_t  param;
  bn_stats_t  stats;
  logic       stats_valid;
  bn_replay_t replay;
  logic       replay_valid;

  bn_input_ctrl u_input_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .x_i            (x_i),
    .x_valid_i      (x_valid_i),
    .mode_i         (mode_i),
    .param_i        (param_i),
    .param_valid_i  (param_valid_i),
    .train_o        (train),
    .train_valid_o  (train_valid),
    .bypass_o       (bypass),
    .bypass_valid_o (bypass_valid),
    .param_o        (param)
  );

  ////////////////////
  // Training path, stats and buffer side by side
  batch_stats u_batch_stats (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .train_i       (train),
    .train_valid_i (train_valid),
    .stats_o       (stats),
    .stats_valid_o (stats_valid)
  );

  sample_buffer u_sample_buffer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .train_i        (train),
    .train_valid_i  (train_valid),
    .replay_o       (replay),
    .replay_valid_o (replay_valid)
  );

  bn_transform u_transform (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .stats_i        (stats),
    .stats_valid_i  (stats_valid),
    .replay_i       (replay),
    .replay_valid_i (replay_valid),
    .bypass_i       (bypass),
    .bypass_valid_i (bypass_valid),
    .param_i        (param),
    .y_o            (y_o),
    .y_valid_o      (y_valid_o)
  );

endmodule

`default_nettype wire

/* hdl/bn_transform.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bn_config.svh"

module bn_transform
  import bn_data_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire bn_stats_t  stats_i,
  input  wire logic       stats_valid_i,
  input  wire bn_replay_t replay_i,
  input  wire logic       replay_valid_i,
  input  wire bn_data_t   bypass_i,
  input  wire logic       bypass_valid_i,
  input  wire bn_param_t  param_i,
  output bn_data_t        y_o,
  output logic            y_valid_o
);

  localparam logic signed [33:0] SAT_MAX = (34'sd1 <<< (`BN_DATA_W - 1)) - 34'sd1;
  localparam logic signed [33:0] SAT_MIN = -(34'sd1 <<< (`BN_DATA_W - 1));

  bn_stats_t          stats_hold_q;
  bn_stats_t          batch_stats_q;
  bn_param_t          batch_param_q;

  bn_stats_t          cur_stats;
  bn_stats_t          use_stats;
  bn_param_t          use_param;
  logic signed [16:0] diff;
  logic signed [32:0] prod;
  logic [5:0]         sh;
  logic signed [32:0] scaled;
  logic signed [33:0] acc;
  bn_data_t           y_nx;

  ////////////////////
  // Normalize datapath
  always_comb begin
    // Stats pulse lines up with the first replay word
    cur_stats = stats_valid_i ? stats_i : stats_hold_q;
    use_stats = replay_i.first ? cur_stats : batch_stats_q;
    use_param = replay_i.first ? param_i : batch_param_q;

    diff   = $signed({replay_i.data[`BN_DATA_W-1], replay_i.data})
           - $signed({use_stats.mean[`BN_DATA_W-1], use_stats.mean});
    prod   = diff * $signed(use_param.gamma);
    sh     = 6'(`BN_GAMMA_FRAC) + 6'(use_stats.k);
    scaled = prod >>> sh;
    acc    = 34'(scaled) + 34'($signed(use_param.beta));

    // Saturate to the sample width
    if (acc > SAT_MAX) begin
      y_nx = SAT_MAX[`BN_DATA_W-1:0];
    end else if (acc < SAT_MIN) begin
      y_nx = SAT_MIN[`BN_DATA_W-1:0];
    end else begin
      y_nx = acc[`BN_DATA_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (stats_valid_i) begin
      stats_hold_q <= stats_i;
    end
    // Freeze stats and params for the whole batch
    if (replay_valid_i && replay_i.first) begin
      batch_stats_q <= cur_stats;
      batch_param_q <= param_i;
    end
    if (replay_valid_i) begin
      y_o <= y_nx;
    end else if (bypass_valid_i) begin
      y_o <= bypass_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      y_valid_o <= 1'b0;
    end else begin
      y_valid_o <= replay_valid_i || bypass_valid_i;
    end
  end

  // Replay and bypass come from different blocks and must never overlap
  a_no_path_overlap: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(replay_valid_i && bypass_valid_i)
  );

endmodule

`default_nettype wire

/* hdl/sample_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bn_config.svh"

module sample_buffer
  import bn_data_pkg::*;
  import bn_ctrl_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire bn_sample_t train_i,
  input  wire logic       train_valid_i,
  output bn_replay_t      replay_o,
  output logic            replay_valid_o
);

  // Two banks, one filling and one replaying
  bn_data_t             mem_q [2][`BN_MINI_BATCH];

  replay_state_e        state_q;
  logic                 fill_bank_q;
  logic                 rd_bank_q;
  logic [`BN_IDX_W-1:0] rd_idx_q;
  logic                 swap;

  assign swap = train_valid_i && train_i.last;

  always_ff @(posedge clk_i) begin
    if (train_valid_i) begin
      mem_q[fill_bank_q][train_i.idx] <= train_i.data;
    end
  end

  ////////////////////
  // Replay FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q        <= RP_IDLE;
      fill_bank_q    <= 1'b0;
      rd_bank_q      <= 1'b0;
      rd_idx_q       <= '0;
      replay_valid_o <= 1'b0;
    end else begin
      case (state_q)
        RP_IDLE: begin
          replay_valid_o <= swap;
          if (swap) begin
            // Word 0 goes out now, replay continues from 1
            rd_bank_q   <= fill_bank_q;
            fill_bank_q <= ~fill_bank_q;
            rd_idx_q    <= `BN_IDX_W'(1);
            state_q     <= RP_RUN;
          end
        end
        RP_RUN: begin
          replay_valid_o <= 1'b1;
          rd_idx_q       <= rd_idx_q + 1'b1;
          if (rd_idx_q == `BN_IDX_W'(`BN_MINI_BATCH - 1)) begin
            state_q <= RP_IDLE;
          end
        end
        default: state_q <= RP_IDLE;
      endcase
    end
  end

  // Replay word and first marker
  always_ff @(posedge clk_i) begin
    if (state_q == RP_RUN) begin
      replay_o.data  <= mem_q[rd_bank_q][rd_idx_q];
      replay_o.first <= 1'b0;
    end else begin
      replay_o.data  <= mem_q[fill_bank_q][0];
      replay_o.first <= 1'b1;
    end
  end

  // Next batch must not complete before the current replay ends
  a_no_swap_in_replay: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    swap |-> (state_q == RP_IDLE)
  );

endmodule

`default_nettype wire

/* include/bn_config.svh */
`ifndef BN_CONFIG_SVH
`define BN_CONFIG_SVH

// Sample word and batch geometry
`define BN_DATA_W       16
`define BN_MINI_BATCH   8
`define BN_IDX_W        3

// Batch sum needs IDX_W guard bits above the sample width
`define BN_SUM_W        19

// Gamma is Q8.8
`define BN_GAMMA_FRAC   8

// Deviation shift is leading one of the range minus this offset
`define BN_APPROX_SHIFT 2

`endif

/* verification/bn_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module bn_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset low over the first two rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* verification/bn_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bn_config.svh"

module bn_tb
  import bn_data_pkg::*;
  import bn_ctrl_pkg::*;
();

  logic      clk;
  logic      rst_n;
  bn_data_t  x;
  logic      x_valid;
  bn_mode_e  mode;
  bn_param_t param;
  logic      param_valid;
  bn_data_t  y;
  logic      y_valid;

  int        seed;
  int        cyc = 0;
  string     test_name;
  bn_param_t cur_param;
  int        next_tag = 0;
  int        out_cnt [64];
  int        last_drv [64];

  // Expected outputs in order, with batch tag and drive cycle
  bn_data_t  exp_q [$];
  int        tag_q [$];
  int        drv_q [$];

  bn_data_t  mon_exp;
  int        mon_tag;
  int        mon_drv;

  bn_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  bn_top dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .x_i           (x),
    .x_valid_i     (x_valid),
    .mode_i        (mode),
    .param_i       (param),
    .param_valid_i (param_valid),
    .y_o           (y),
    .y_valid_o     (y_valid)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input bn_data_t exp, input bn_data_t act);
    if (exp !== act) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////
  // Reference model of the batch arithmetic
  function automatic void expect_batch(input bn_data_t b [`BN_MINI_BATCH],
                                       input bn_param_t p, input int tag);
    int     sum;
    int     mx;
    int     mn;
    int     mean;
    int     range;
    int     lead;
    int     k;
    longint v;
    sum = 0;
    mx  = b[0];
    mn  = b[0];
    foreach (b[i]) begin
      sum += b[i];
      if (b[i] > mx) begin
        mx = b[i];
      end
      if (b[i] < mn) begin
        mn = b[i];
      end
    end
    // Floor of sum / 8
    mean  = sum >>> 3;
    range = mx - mn;
    lead  = 0;
    for (int i = 0; i < 32; i++) begin
      if (range[i]) begin
        lead = i;
      end
    end
    k = lead - `BN_APPROX_SHIFT;
    if (k < 0) begin
      k = 0;
    end
    foreach (b[i]) begin
      v = ((longint'(b[i] - mean) * p.gamma) >>> (`BN_GAMMA_FRAC + k)) + p.beta;
      if (v > 32767) begin
        v = 32767;
      end else if (v < -32768) begin
        v = -32768;
      end
      exp_q.push_back(`BN_DATA_W'(v));
      tag_q.push_back(tag);
      drv_q.push_back(-1);
    end
  endfunction

  ////////////////////
  // Output compare
  always @(posedge clk) begin
    if (rst_n === 1'b1 && y_valid !== 1'b0) begin
      if (y_valid !== 1'b1) begin
        $display("Output valid is unknown in test %s", test_name);
        stop_run();
      end else if (exp_q.size() == 0) begin
        $display("Output %0d appeared in test %s when none was expected", y, test_name);
        stop_run();
      end else begin
        mon_exp = exp_q.pop_front();
        mon_tag = tag_q.pop_front();
        mon_drv = drv_q.pop_front();
        check_data(test_name, mon_exp, y);
        if (mon_tag >= 0) begin
          // Batch words leave on consecutive cycles, three after the last sample
          check_count({test_name, " batch latency"}, 3 + out_cnt[mon_tag],
                      cyc - 1 - last_drv[mon_tag]);
          out_cnt[mon_tag] = out_cnt[mon_tag] + 1;
        end else begin
          // Seen one edge after y_valid rose
          check_count({test_name, " latency"}, 2, cyc - 1 - mon_drv);
        end
      end
    end
  end

  task automatic tick_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      x_valid     <= 1'b0;
      param_valid <= 1'b0;
    end
  endtask

  task automatic set_mode(input bn_mode_e m);
    @(posedge clk);
    mode        <= m;
    x_valid     <= 1'b0;
    param_valid <= 1'b0;
  endtask

  task automatic load_param(input bn_param_t p);
    @(posedge clk);
    param       <= p;
    param_valid <= 1'b1;
    x_valid     <= 1'b0;
    cur_param = p;
  endtask

  task automatic send_bypass(input bn_data_t v);
    @(posedge clk);
    x           <= v;
    x_valid     <= 1'b1;
    param_valid <= 1'b0;
    exp_q.push_back(v);
    tag_q.push_back(-1);
    drv_q.push_back(cyc);
  endtask

  task automatic send_batch(input bn_data_t b [`BN_MINI_BATCH]);
    int tag;
    tag = next_tag;
    expect_batch(b, cur_param, tag);
    next_tag++;
    foreach (b[i]) begin
      @(posedge clk);
      x           <= b[i];
      x_valid     <= 1'b1;
      param_valid <= 1'b0;
    end
    last_drv[tag] = cyc;
  endtask

  task automatic wait_reset(input int limit);
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was not released within %0d cycles", limit);
      stop_run();
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Test %s timed out with %0d outputs missing", test_name, exp_q.size());
      stop_run();
    end
  endtask

  task automatic check_batches(input int first_tag);
    for (int t = first_tag; t < next_tag; t++) begin
      check_count($sformatf("%s batch %0d count", test_name, t), `BN_MINI_BATCH, out_cnt[t]);
    end
  endtask

  ////////////////////
  // Test sequence
  initial begin
    bn_data_t  b [`BN_MINI_BATCH];
    bn_param_t p;
    int        first_tag;
    seed        = 52;
    x           = '0;
    x_valid     = 1'b0;
    mode        = MODE_BYPASS;
    param       = '0;
    param_valid = 1'b0;
    cur_param.gamma = `BN_DATA_W'(1 << `BN_GAMMA_FRAC);
    cur_param.beta  = '0;

    // Idle after reset, any output is flagged by the compare
    test_name = "reset";
    wait_reset(20);
    tick_idle(6);

    test_name = "bypass";
    for (int i = 0; i < 6; i++) begin
      send_bypass(`BN_DATA_W'($random(seed)));
    end
    tick_idle(1);
    wait_drain(20);

    // Unit gamma, zero beta from reset
    test_name = "train_unit";
    set_mode(MODE_TRAIN);
    first_tag = next_tag;
    foreach (b[i]) begin
      b[i] = `BN_DATA_W'($random(seed));
    end
    send_batch(b);
    tick_idle(1);
    wait_drain(40);
    check_batches(first_tag);

    // Next batch gathers while the previous one replays
    test_name = "train_random";
    first_tag = next_tag;
    for (int n = 0; n < 4; n++) begin
      p.gamma = `BN_DATA_W'($random(seed));
      p.beta  = `BN_DATA_W'($random(seed));
      load_param(p);
      foreach (b[i]) begin
        b[i] = `BN_DATA_W'($random(seed));
      end
      send_batch(b);
      tick_idle(3);
    end
    wait_drain(60);
    check_batches(first_tag);

    // Zero range, small range with k clamped, then full range with saturation on both sides
    test_name = "train_corner";
    first_tag = next_tag;
    for (int c = 0; c < 4; c++) begin
      case (c)
        0: begin
          p.gamma = `BN_DATA_W'($random(seed));
          p.beta  = 16'sh0055;
        end
        1: begin
          p.gamma = 16'sh4000;
          p.beta  = 16'sh0055;
        end
        2: begin
          p.gamma = 16'sh7fff;
          p.beta  = 16'sh7f00;
        end
        default: begin
          p.gamma = 16'sh8000;
          p.beta  = 16'sh8100;
        end
      endcase
      load_param(p);
      foreach (b[i]) begin
        if (c == 0) begin
          b[i] = 16'sd1234;
        end else if (c == 1) begin
          b[i] = bn_data_t'(1234 + i % 4);
        end else begin
          b[i] = i[0] ? 16'sh8000 : 16'sh7fff;
        end
      end
      send_batch(b);
      tick_idle(3);
    end
    wait_drain(60);
    check_batches(first_tag);

    // Back to bypass once training has drained
    test_name = "bypass_after_train";
    set_mode(MODE_BYPASS);
    for (int i = 0; i < 5; i++) begin
      send_bypass(`BN_DATA_W'($random(seed)));
    end
    tick_idle(1);
    wait_drain(20);
    check_batches(0);
    tick_idle(5);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
